// ==== logic/uart_config.svh ====
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// ====================
// serial timing
// ====================

// clocks per serial bit, even and at least 8
`define UART_CLKS_PER_BIT 16

// data bits per frame
`define UART_DATA_BITS 8

// flops in the receive synchronizer
`define UART_SYNC_STAGES 3

// ====================
// bus
// ====================

`define UART_APB_ADDR_W 4

`endif

// ==== logic/uart_pkg.sv ====
`include "uart_config.svh"

package uart_pkg;

    // ====================
    // data
    // ====================

    typedef logic [`UART_DATA_BITS-1:0] byte_t;

    // ====================
    // register map
    // ====================

    typedef enum logic [`UART_APB_ADDR_W-1:0] {
        ADDR_DATA   = `UART_APB_ADDR_W'(0),
        ADDR_STATUS = `UART_APB_ADDR_W'(4),
        ADDR_CTRL   = `UART_APB_ADDR_W'(8)
    } reg_addr_e;

    // status read value, ti in bit 0
    typedef struct packed {
        logic [`UART_DATA_BITS-5:0] reserved;
        logic                       tx_busy;
        logic                       ren;
        logic                       ri;
        logic                       ti;
    } status_t;

endpackage

// ==== logic/uart_tx_if.sv ====
// link from the register block to the transmitter
interface uart_tx_if;

    // one-cycle request, only while busy is low
    logic            start;
    uart_pkg::byte_t data;

    // done pulses in the cycle busy falls
    logic            busy;
    logic            done;

    modport regs (
        output start,
        output data,
        input  busy,
        input  done
    );

    modport tx (
        input  start,
        input  data,
        output busy,
        output done
    );

endinterface

// ==== logic/uart_apb_regs.sv ====
`include "uart_config.svh"

module uart_apb_regs (
    input  logic                        clk,
    input  logic                        reset_n,

    // APB slave
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [`UART_APB_ADDR_W-1:0] paddr,
    input  uart_pkg::byte_t             pwdata,
    output uart_pkg::byte_t             prdata,
    output logic                        pready,
    output logic                        pslverr,

    // receiver
    input  logic                        rx_valid,
    input  uart_pkg::byte_t             rx_data,
    output logic                        rx_enable,

    // flags
    output logic                        ti,
    output logic                        ri,

    uart_tx_if.regs                     tx
);

    logic            access;
    logic            data_wr;
    logic            data_wr_ok;
    logic            data_rd;
    logic            ctrl_wr;
    logic            ren;
    uart_pkg::byte_t rx_hold;
    uart_pkg::status_t status;

    // ====================
    // decode
    // ====================

    // transfers complete in the access phase, no wait states
    assign access     = psel & penable;
    assign data_wr    = access & pwrite & (paddr == uart_pkg::ADDR_DATA);
    assign data_rd    = access & ~pwrite & (paddr == uart_pkg::ADDR_DATA);
    assign ctrl_wr    = access & pwrite & (paddr == uart_pkg::ADDR_CTRL);
    assign data_wr_ok = data_wr & ~tx.busy;

    assign pready  = 1'b1;
    // a byte written while the frame is still going out is dropped
    assign pslverr = data_wr & tx.busy;

    assign tx.start = data_wr_ok;
    assign tx.data  = pwdata;

    // ====================
    // control and flags
    // ====================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ren <= 1'b0;
        end else if (ctrl_wr) begin
            ren <= pwdata[0];
        end
    end

    assign rx_enable = ren;

    // a write in the done cycle starts the next frame, so it wins
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ti <= 1'b0;
        end else if (data_wr_ok) begin
            ti <= 1'b0;
        end else if (tx.done) begin
            ti <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ri <= 1'b0;
        end else if (rx_valid) begin
            ri <= 1'b1;
        end else if (data_rd) begin
            ri <= 1'b0;
        end
    end

    // newest byte wins, even if ri is still set
    always_ff @(posedge clk) begin
        if (rx_valid) begin
            rx_hold <= rx_data;
        end
    end

    // ====================
    // read mux
    // ====================

    always_comb begin
        status          = '0;
        status.tx_busy  = tx.busy;
        status.ren      = ren;
        status.ri       = ri;
        status.ti       = ti;
    end

    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            case (paddr)
                uart_pkg::ADDR_DATA:   prdata = rx_hold;
                uart_pkg::ADDR_STATUS: prdata = status;
                uart_pkg::ADDR_CTRL:   prdata = uart_pkg::byte_t'(ren);
                default:               prdata = '0;
            endcase
        end
    end

endmodule

// ==== logic/uart_tx.sv ====
`include "uart_config.svh"

module uart_tx (
    input  logic  clk,
    input  logic  reset_n,
    uart_tx_if.tx tx,
    output logic  txd
);

    localparam int CPB        = `UART_CLKS_PER_BIT;
    localparam int FRAME_BITS = `UART_DATA_BITS + 2;
    localparam int CNT_W      = $clog2(CPB);
    localparam int BIT_W      = $clog2(FRAME_BITS);

    logic [FRAME_BITS-1:0] shift_q;
    logic [CNT_W-1:0]      baud_cnt;
    logic [BIT_W-1:0]      bit_cnt;
    logic                  bit_end;
    logic                  last_bit;

    assign bit_end  = (baud_cnt == CNT_W'(CPB - 1));
    assign last_bit = (bit_cnt == BIT_W'(FRAME_BITS - 1));

    // ====================
    // bit timer
    // ====================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            baud_cnt <= '0;
        end else if (tx.start || bit_end) begin
            baud_cnt <= '0;
        end else if (tx.busy) begin
            baud_cnt <= baud_cnt + CNT_W'(1);
        end
    end

    // ====================
    // frame shifter
    // ====================

    // idle line is all ones, so txd rests high
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            shift_q <= '1;
            bit_cnt <= '0;
            tx.busy <= 1'b0;
            tx.done <= 1'b0;
        end else begin
            tx.done <= 1'b0;
            if (tx.start) begin
                // stop, data, start; LSB goes out first
                shift_q <= {1'b1, tx.data, 1'b0};
                bit_cnt <= '0;
                tx.busy <= 1'b1;
            end else if (tx.busy && bit_end) begin
                if (last_bit) begin
                    shift_q <= '1;
                    bit_cnt <= '0;
                    tx.busy <= 1'b0;
                    tx.done <= 1'b1;
                end else begin
                    shift_q <= {1'b1, shift_q[FRAME_BITS-1:1]};
                    bit_cnt <= bit_cnt + BIT_W'(1);
                end
            end
        end
    end

    assign txd = shift_q[0];

endmodule

// ==== logic/uart_rx.sv ====
`include "uart_config.svh"

module uart_rx (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            rxd,
    input  logic            rx_enable,
    output logic            rx_valid,
    output uart_pkg::byte_t rx_data
);

    localparam int CPB   = `UART_CLKS_PER_BIT;
    localparam int SYNC  = `UART_SYNC_STAGES;
    localparam int DBITS = `UART_DATA_BITS;
    localparam int CNT_W = $clog2(CPB);
    localparam int BIT_W = $clog2(DBITS);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    rx_state_e       state;
    logic [SYNC-1:0] sync_q;
    logic            rx_s;
    logic            fall;
    logic [CNT_W-1:0] baud_cnt;
    logic [BIT_W-1:0] bit_cnt;
    logic            half_pt;
    logic            sample_pt;
    uart_pkg::byte_t shift_q;

    // ====================
    // synchronizer
    // ====================

    // preset high so reset does not look like a start edge
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sync_q <= '1;
        end else begin
            sync_q <= {sync_q[SYNC-2:0], rxd};
        end
    end

    assign rx_s = sync_q[SYNC-1];
    // high now, low on the next stage in
    assign fall = rx_s & ~sync_q[SYNC-2];

    assign half_pt   = (baud_cnt == CNT_W'(CPB / 2));
    assign sample_pt = (baud_cnt == CNT_W'(CPB - 1));

    // ====================
    // frame FSM
    // ====================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state    <= RX_IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (!rx_enable) begin
            // REN dropped mid frame
            state <= RX_IDLE;
        end else begin
            case (state)
                RX_IDLE: begin
                    baud_cnt <= '0;
                    if (fall) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (half_pt) begin
                        baud_cnt <= '0;
                        bit_cnt  <= '0;
                        // short low pulse, back to idle
                        state    <= rx_s ? RX_IDLE : RX_DATA;
                    end else begin
                        baud_cnt <= baud_cnt + CNT_W'(1);
                    end
                end
                RX_DATA: begin
                    if (sample_pt) begin
                        baud_cnt <= '0;
                        if (bit_cnt == BIT_W'(DBITS - 1)) begin
                            state <= RX_STOP;
                        end else begin
                            bit_cnt <= bit_cnt + BIT_W'(1);
                        end
                    end else begin
                        baud_cnt <= baud_cnt + CNT_W'(1);
                    end
                end
                default: begin
                    // stop bit value is not checked
                    if (sample_pt) begin
                        baud_cnt <= '0;
                        state    <= RX_IDLE;
                    end else begin
                        baud_cnt <= baud_cnt + CNT_W'(1);
                    end
                end
            endcase
        end
    end

    // LSB arrives first, shift in from the top
    always_ff @(posedge clk) begin
        if (rx_enable && state == RX_DATA && sample_pt) begin
            shift_q <= {rx_s, shift_q[DBITS-1:1]};
        end
    end

    assign rx_valid = rx_enable & (state == RX_STOP) & sample_pt;
    assign rx_data  = shift_q;

endmodule

// ==== logic/uart_top.sv ====
`include "uart_config.svh"

module uart_top (
    input  logic                        clk,
    input  logic                        reset_n,

    // APB
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [`UART_APB_ADDR_W-1:0] paddr,
    input  uart_pkg::byte_t             pwdata,
    output uart_pkg::byte_t             prdata,
    output logic                        pready,
    output logic                        pslverr,

    // serial line and flags
    input  logic                        rxd,
    output logic                        txd,
    output logic                        ti,
    output logic                        ri
);

    logic            rx_enable;
    logic            rx_valid;
    uart_pkg::byte_t rx_data;

    uart_tx_if i_tx_if ();

    uart_apb_regs i_regs (
        .clk       (clk),
        .reset_n   (reset_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .rx_valid  (rx_valid),
        .rx_data   (rx_data),
        .rx_enable (rx_enable),
        .ti        (ti),
        .ri        (ri),
        .tx        (i_tx_if.regs)
    );

    uart_tx i_tx (
        .clk     (clk),
        .reset_n (reset_n),
        .tx      (i_tx_if.tx),
        .txd     (txd)
    );

    uart_rx i_rx (
        .clk       (clk),
        .reset_n   (reset_n),
        .rxd       (rxd),
        .rx_enable (rx_enable),
        .rx_valid  (rx_valid),
        .rx_data   (rx_data)
    );

endmodule

// ==== tests/uart_tb.sv ====
`include "uart_config.svh"

module uart_tb;

    localparam int CPB            = `UART_CLKS_PER_BIT;
    localparam int DBITS          = `UART_DATA_BITS;
    localparam int FRAME          = DBITS + 2;
    localparam int AW             = `UART_APB_ADDR_W;
    localparam int TIMEOUT_CYCLES = 20 * 10 * CPB + 500;

    logic            clk;
    logic            reset_n;
    logic            psel;
    logic            penable;
    logic            pwrite;
    logic [AW-1:0]   paddr;
    uart_pkg::byte_t pwdata;
    uart_pkg::byte_t prdata;
    logic            pready;
    logic            pslverr;
    logic            rxd;
    logic            txd;
    logic            ti;
    logic            ri;

    int              check_count;
    int              fail_count;
    int              test_mark;
    int              cycle_count;
    uart_pkg::byte_t tx_queue[$];
    event            frame_started;

    uart_top i_uart_top (
        .clk     (clk),
        .reset_n (reset_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .rxd     (rxd),
        .txd     (txd),
        .ti      (ti),
        .ri      (ri)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run went past %0d cycles without finishing", TIMEOUT_CYCLES);
            $display("Checks failed");
            $finish;
        end
    end

    // ====================
    // helpers
    // ====================

    // start bit in bit 0, stop bit on top
    function automatic logic [FRAME-1:0] frame_bits(input uart_pkg::byte_t b);
        logic [FRAME-1:0] f;
        f[0] = 1'b0;
        for (int i = 0; i < DBITS; i++) begin
            f[i+1] = b[i];
        end
        f[FRAME-1] = 1'b1;
        return f;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            fail_count++;
        end
    endtask

    // setup phase, then access phase; error flag sampled mid access cycle
    task automatic write_reg(input logic [AW-1:0] addr, input uart_pkg::byte_t data,
                             output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        #1 err = pslverr;
        @(posedge clk);
        if (addr == uart_pkg::ADDR_DATA && !err) begin
            tx_queue.push_back(data);
            -> frame_started;
        end
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic read_reg(input logic [AW-1:0] addr, output uart_pkg::byte_t data);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        #1 data = prdata;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic send_frame(input uart_pkg::byte_t b);
        logic [FRAME-1:0] f;
        f = frame_bits(b);
        for (int i = 0; i < FRAME; i++) begin
            @(negedge clk);
            rxd = f[i];
            repeat (CPB - 1) @(negedge clk);
        end
    endtask

    task automatic wait_for_flag(input bit want_ri, input int limit);
        int n;
        n = 0;
        while (((want_ri ? ri : ti) !== 1'b1) && n < limit) begin
            @(negedge clk);
            n++;
        end
        check_count++;
        if (n >= limit) begin
            $display("%s did not rise within %0d cycles", want_ri ? "ri" : "ti", limit);
            fail_count++;
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s: %s", name, (fail_count == test_mark) ? "ok" : "has errors");
        test_mark = fail_count;
    endtask

    // ====================
    // txd compare
    // ====================

    // bit i sampled near its centre, counted from the access cycle
    initial begin : compare_txd
        uart_pkg::byte_t  b;
        logic [FRAME-1:0] exp;
        forever begin
            @(frame_started);
            b   = tx_queue.pop_front();
            exp = frame_bits(b);
            repeat (CPB / 2) @(negedge clk);
            for (int i = 0; i < FRAME; i++) begin
                compare_value($sformatf("txd bit %0d", i), 32'(txd), 32'(exp[i]));
                if (i != FRAME - 1) begin
                    repeat (CPB) @(negedge clk);
                end
            end
        end
    end

    // ====================
    // tests
    // ====================

    initial begin : run_tests
        uart_pkg::byte_t   b;
        uart_pkg::byte_t   rd;
        logic              err;
        uart_pkg::status_t exp_status;
        check_count = 0;
        fail_count  = 0;
        test_mark   = 0;
        cycle_count = 0;
        reset_n     = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        rxd         = 1'b1;
        void'($urandom(32'h5547));
        repeat (3) @(negedge clk);
        reset_n = 1'b1;

        read_reg(uart_pkg::ADDR_STATUS, rd);
        compare_value("status", 32'(rd), 0);
        read_reg(uart_pkg::ADDR_CTRL, rd);
        compare_value("ctrl", 32'(rd), 0);
        compare_value("txd", 32'(txd), 1);
        compare_value("ti", 32'(ti), 0);
        compare_value("ri", 32'(ri), 0);
        compare_value("pready", 32'(pready), 1);
        compare_value("pslverr", 32'(pslverr), 0);
        end_test("reset values");

        for (int k = 0; k < 4; k++) begin
            b = uart_pkg::byte_t'($urandom());
            write_reg(uart_pkg::ADDR_DATA, b, err);
            compare_value("pslverr", 32'(err), 0);
            compare_value("ti", 32'(ti), 0);
            wait_for_flag(1'b0, 12 * CPB);
        end
        end_test("transmit");

        // second byte must be refused while the first is on the line
        write_reg(uart_pkg::ADDR_DATA, uart_pkg::byte_t'($urandom()), err);
        compare_value("pslverr", 32'(err), 0);
        read_reg(uart_pkg::ADDR_STATUS, rd);
        exp_status         = '0;
        exp_status.tx_busy = 1'b1;
        compare_value("status", 32'(rd), 32'(exp_status));
        write_reg(uart_pkg::ADDR_DATA, uart_pkg::byte_t'($urandom()), err);
        compare_value("pslverr", 32'(err), 1);
        wait_for_flag(1'b0, 12 * CPB);
        end_test("back-pressure");

        write_reg(uart_pkg::ADDR_CTRL, 8'h01, err);
        for (int k = 0; k < 4; k++) begin
            b = uart_pkg::byte_t'($urandom());
            send_frame(b);
            wait_for_flag(1'b1, 4 * CPB);
            read_reg(uart_pkg::ADDR_DATA, rd);
            compare_value("rx data", 32'(rd), 32'(b));
            compare_value("ri", 32'(ri), 0);
        end
        end_test("receive");

        write_reg(uart_pkg::ADDR_CTRL, 8'h00, err);
        send_frame(uart_pkg::byte_t'($urandom()));
        repeat (2 * CPB) @(negedge clk);
        compare_value("ri", 32'(ri), 0);
        write_reg(uart_pkg::ADDR_CTRL, 8'h01, err);
        // low pulse well short of the half-bit check
        @(negedge clk);
        rxd = 1'b0;
        repeat (CPB / 4) @(negedge clk);
        rxd = 1'b1;
        // long enough for a falsely started frame to reach its stop bit
        repeat ((FRAME + 1) * CPB) @(negedge clk);
        compare_value("ri", 32'(ri), 0);
        b = uart_pkg::byte_t'($urandom());
        send_frame(b);
        wait_for_flag(1'b1, 4 * CPB);
        read_reg(uart_pkg::ADDR_DATA, rd);
        compare_value("rx data", 32'(rd), 32'(b));
        compare_value("ri", 32'(ri), 0);
        end_test("receive disabled and glitch");

        $display("checks run %0d, passed %0d, failed %0d",
                 check_count, check_count - fail_count, fail_count);
        if (fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== uart.f ====
+incdir+logic
logic/uart_pkg.sv
logic/uart_tx_if.sv
logic/uart_apb_regs.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_top.sv
tests/uart_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the UART testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary -j 0 --top-module uart_tb -f uart.f -o uart_sim

./obj_dir/uart_sim | tee sim.log

if grep -q "All checks passed" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
